// ==== include/image_mean_config.svh ====
`ifndef IMAGE_MEAN_CONFIG_SVH
`define IMAGE_MEAN_CONFIG_SVH

// Pixel sample width on the stream.
`define PIXEL_WIDTH 8

// Row and column position counters.
`define ROW_WIDTH 12
`define COL_WIDTH 12

// One phase sees a quarter of the frame, so two position bits drop out.
`define ACCUM_WIDTH (`ROW_WIDTH + `COL_WIDTH + `PIXEL_WIDTH - 2)
`define COUNT_WIDTH (`ROW_WIDTH + `COL_WIDTH - 2)

// Register terminal data path.
`define DATA_WIDTH 32

// Terminal address that selects this block.
`define TERM_IMAGE_MEAN 16'h0021

// Stream data type code.
`define DTYPE_WIDTH 4

`endif

// ==== design/stream_pkg.sv ====
`include "image_mean_config.svh"

package stream_pkg;

   // Bit of the data type code that marks a pixel word.
   localparam int unsigned pixel_bit = 3;

   typedef enum logic [`DTYPE_WIDTH-1:0] {
      frame_start = 4'b0001,
      row_end     = 4'b0010,
      pixel_even  = 4'b1000,
      pixel_odd   = 4'b1001
   } dtype_e;

   // Row parity first, then column parity.
   typedef enum logic [1:0] {
      phase_00 = 2'b00,
      phase_01 = 2'b01,
      phase_10 = 2'b10,
      phase_11 = 2'b11
   } bayer_phase_e;

   typedef struct packed {
      logic                    valid;
      logic                    clear;
      logic                    accumulate;
      bayer_phase_e            phase;
      logic [`PIXEL_WIDTH-1:0] pixel;
      logic                    window_done;
   } pix_event_t;

   function automatic logic is_pixel(dtype_e dtype);
      return dtype[pixel_bit];
   endfunction

endpackage

// ==== design/regs_pkg.sv ====
`include "image_mean_config.svh"

package regs_pkg;

   typedef enum logic [31:0] {
      addr_row_start = 32'h0,
      addr_row_end   = 32'h1,
      addr_col_start = 32'h2,
      addr_col_end   = 32'h3,
      addr_accum00   = 32'h4,
      addr_accum01   = 32'h5,
      addr_accum10   = 32'h6,
      addr_accum11   = 32'h7,
      addr_count     = 32'h8,
      addr_status    = 32'h9
   } reg_addr_e;

   // Start is inclusive and end is exclusive on both axes.
   typedef struct packed {
      logic [`ROW_WIDTH-1:0] row_start;
      logic [`ROW_WIDTH-1:0] row_end;
      logic [`COL_WIDTH-1:0] col_start;
      logic [`COL_WIDTH-1:0] col_end;
   } window_t;

   typedef struct packed {
      logic [`ACCUM_WIDTH-1:0] accum00;
      logic [`ACCUM_WIDTH-1:0] accum01;
      logic [`ACCUM_WIDTH-1:0] accum10;
      logic [`ACCUM_WIDTH-1:0] accum11;
      logic [`COUNT_WIDTH-1:0] count;
   } mean_result_t;

endpackage

// ==== design/mean_reg_terminal.sv ====
`timescale 1ns/1ps

`include "image_mean_config.svh"

module mean_reg_terminal
   import regs_pkg::*;
(
   input  logic                   pixclk,
   input  logic                   resetb,
   input  logic [15:0]            term_addr,
   input  reg_addr_e              reg_addr,
   input  logic                   read,
   input  logic                   write,
   input  logic [`DATA_WIDTH-1:0] reg_datai,
   input  mean_result_t           result,
   input  logic                   busy,
   output logic                   en,
   output logic [`DATA_WIDTH-1:0] reg_datao,
   output window_t                window
);

   localparam int unsigned accum_pad = `DATA_WIDTH - `ACCUM_WIDTH;
   localparam int unsigned count_pad = `DATA_WIDTH - `COUNT_WIDTH;
   localparam int unsigned row_pad   = `DATA_WIDTH - `ROW_WIDTH;
   localparam int unsigned col_pad   = `DATA_WIDTH - `COL_WIDTH;

   assign en = (term_addr == `TERM_IMAGE_MEAN);

   // Window registers take the low bits of the write data.
   always_ff @(posedge pixclk or negedge resetb) begin
      if (!resetb) begin
         window <= '0;
      end else if (en && write) begin
         case (reg_addr)
            addr_row_start: window.row_start <= reg_datai[`ROW_WIDTH-1:0];
            addr_row_end:   window.row_end   <= reg_datai[`ROW_WIDTH-1:0];
            addr_col_start: window.col_start <= reg_datai[`COL_WIDTH-1:0];
            addr_col_end:   window.col_end   <= reg_datai[`COL_WIDTH-1:0];
            default: ;
         endcase
      end
   end

   // Reads are always ready and have no side effect.
   // The data path follows the address whenever the terminal is selected.
   always_comb begin
      reg_datao = '0;
      if (en) begin
         case (reg_addr)
            addr_row_start: reg_datao = {{row_pad{1'b0}}, window.row_start};
            addr_row_end:   reg_datao = {{row_pad{1'b0}}, window.row_end};
            addr_col_start: reg_datao = {{col_pad{1'b0}}, window.col_start};
            addr_col_end:   reg_datao = {{col_pad{1'b0}}, window.col_end};
            addr_accum00:   reg_datao = {{accum_pad{1'b0}}, result.accum00};
            addr_accum01:   reg_datao = {{accum_pad{1'b0}}, result.accum01};
            addr_accum10:   reg_datao = {{accum_pad{1'b0}}, result.accum10};
            addr_accum11:   reg_datao = {{accum_pad{1'b0}}, result.accum11};
            addr_count:     reg_datao = {{count_pad{1'b0}}, result.count};
            addr_status:    reg_datao = {{(`DATA_WIDTH-1){1'b0}}, busy};
            default:        reg_datao = '0;
         endcase
      end
   end

endmodule

// ==== design/stream_decode.sv ====
`timescale 1ns/1ps

`include "image_mean_config.svh"

module stream_decode
   import stream_pkg::*;
   import regs_pkg::*;
(
   input  logic                    pixclk,
   input  logic                    resetb,
   input  logic                    dvi,
   input  dtype_e                  dtypei,
   input  logic [`PIXEL_WIDTH-1:0] datai,
   input  window_t                 window,
   output pix_event_t              pix_event
);

   logic [`ROW_WIDTH-1:0]   row;
   logic [`ROW_WIDTH-1:0]   next_row;
   logic [`COL_WIDTH-1:0]   col;
   logic                    pixel_word;
   logic                    in_window;
   logic                    ev_valid;
   logic                    ev_clear;
   logic                    ev_accumulate;
   logic                    ev_window_done;
   bayer_phase_e            ev_phase;
   logic [`PIXEL_WIDTH-1:0] ev_pixel;

   assign next_row   = row + 1'b1;
   assign pixel_word = is_pixel(dtypei);

   assign in_window = (row >= window.row_start) && (row < window.row_end) &&
                      (col >= window.col_start) && (col < window.col_end);

   // Position of the word being presented on the stream.
   always_ff @(posedge pixclk or negedge resetb) begin
      if (!resetb) begin
         row <= '0;
         col <= '0;
      end else if (dvi) begin
         if (dtypei == frame_start) begin
            row <= '0;
            col <= '0;
         end else if (dtypei == row_end) begin
            row <= next_row;
            col <= '0;
         end else if (pixel_word) begin
            col <= col + 1'b1;
         end
      end
   end

   always_ff @(posedge pixclk or negedge resetb) begin
      if (!resetb) begin
         ev_valid       <= 1'b0;
         ev_clear       <= 1'b0;
         ev_accumulate  <= 1'b0;
         ev_window_done <= 1'b0;
      end else begin
         ev_valid       <= dvi;
         ev_clear       <= dvi && (dtypei == frame_start);
         ev_accumulate  <= dvi && pixel_word && in_window;
         // The window closes when the row that just ended was its last one.
         ev_window_done <= dvi && (dtypei == row_end) && (next_row == window.row_end);
      end
   end

   always_ff @(posedge pixclk) begin
      if (dvi) begin
         ev_phase <= bayer_phase_e'({row[0], col[0]});
         ev_pixel <= datai;
      end
   end

   assign pix_event = '{valid:       ev_valid,
                        clear:       ev_clear,
                        accumulate:  ev_accumulate,
                        phase:       ev_phase,
                        pixel:       ev_pixel,
                        window_done: ev_window_done};

endmodule

// ==== design/bayer_accumulate.sv ====
`timescale 1ns/1ps

`include "image_mean_config.svh"

module bayer_accumulate
   import stream_pkg::*;
   import regs_pkg::*;
(
   input  logic         pixclk,
   input  logic         resetb,
   input  pix_event_t   pix_event,
   output mean_result_t sums
);

   logic [`ACCUM_WIDTH-1:0] pixel_ext;

   assign pixel_ext = {{(`ACCUM_WIDTH-`PIXEL_WIDTH){1'b0}}, pix_event.pixel};

   // Running per-phase sums for the frame in progress.
   always_ff @(posedge pixclk or negedge resetb) begin
      if (!resetb) begin
         sums <= '0;
      end else if (pix_event.valid) begin
         if (pix_event.clear) begin
            sums <= '0;
         end else if (pix_event.accumulate) begin
            case (pix_event.phase)
               phase_00: begin
                  sums.accum00 <= sums.accum00 + pixel_ext;
                  sums.count   <= sums.count + 1'b1;
               end
               phase_01: begin
                  sums.accum01 <= sums.accum01 + pixel_ext;
               end
               phase_10: begin
                  sums.accum10 <= sums.accum10 + pixel_ext;
               end
               phase_11: begin
                  sums.accum11 <= sums.accum11 + pixel_ext;
               end
               default: ;
            endcase
         end
      end
   end

endmodule

// ==== design/mean_result.sv ====
`timescale 1ns/1ps

`include "image_mean_config.svh"

module mean_result
   import stream_pkg::*;
   import regs_pkg::*;
(
   input  logic         pixclk,
   input  logic         resetb,
   input  pix_event_t   pix_event,
   input  mean_result_t sums,
   output mean_result_t result,
   output logic         done,
   output logic         busy
);

   typedef enum logic {
      idle,
      accumulating
   } state_e;

   state_e state;

   assign busy = (state == accumulating);

   // A new frame start wins over a completing window.
   always_ff @(posedge pixclk or negedge resetb) begin
      if (!resetb) begin
         state <= idle;
      end else if (pix_event.valid && pix_event.clear) begin
         state <= accumulating;
      end else if (done) begin
         state <= idle;
      end
   end

   // The last in-window pixel reaches the sums before its row end is seen here.
   always_ff @(posedge pixclk or negedge resetb) begin
      if (!resetb) begin
         done   <= 1'b0;
         result <= '0;
      end else begin
         done <= pix_event.valid && pix_event.window_done;
         if (pix_event.valid && pix_event.window_done) begin
            result <= sums;
         end
      end
   end

endmodule

// ==== design/image_mean.sv ====
`timescale 1ns/1ps

`include "image_mean_config.svh"

module image_mean
   import stream_pkg::*;
   import regs_pkg::*;
(
   input  logic                    pixclk,
   input  logic                    resetb,

   input  logic                    dvi,
   input  dtype_e                  dtypei,
   input  logic [`PIXEL_WIDTH-1:0] datai,

   input  logic [15:0]             term_addr,
   input  reg_addr_e               reg_addr,
   input  logic                    read,
   input  logic                    write,
   input  logic [`DATA_WIDTH-1:0]  reg_datai,
   output logic [`DATA_WIDTH-1:0]  reg_datao,
   output logic                    en,

   output logic                    done,
   output logic                    busy,
   output mean_result_t            result
);

   window_t      window;
   pix_event_t   pix_event;
   mean_result_t sums;

   mean_reg_terminal u_terminal (
      .pixclk    (pixclk),
      .resetb    (resetb),
      .term_addr (term_addr),
      .reg_addr  (reg_addr),
      .read      (read),
      .write     (write),
      .reg_datai (reg_datai),
      .result    (result),
      .busy      (busy),
      .en        (en),
      .reg_datao (reg_datao),
      .window    (window)
   );

   stream_decode u_decode (
      .pixclk    (pixclk),
      .resetb    (resetb),
      .dvi       (dvi),
      .dtypei    (dtypei),
      .datai     (datai),
      .window    (window),
      .pix_event (pix_event)
   );

   bayer_accumulate u_accumulate (
      .pixclk    (pixclk),
      .resetb    (resetb),
      .pix_event (pix_event),
      .sums      (sums)
   );

   mean_result u_result (
      .pixclk    (pixclk),
      .resetb    (resetb),
      .pix_event (pix_event),
      .sums      (sums),
      .result    (result),
      .done      (done),
      .busy      (busy)
   );

endmodule

// ==== verif/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
   input  logic reset_req,
   output logic pixclk,
   output logic resetb
);

   initial begin
      pixclk = 1'b0;
      forever #2 pixclk = ~pixclk;
   end

   // Reset is held for five rising edges at power up and again on each request.
   // Release happens on a falling edge so it never lands on a sampling point.
   initial begin
      resetb = 1'b0;
      forever begin
         repeat (5) @(posedge pixclk);
         @(negedge pixclk);
         resetb = 1'b1;
         @(posedge reset_req);
         resetb = 1'b0;
      end
   end

endmodule

// ==== verif/image_mean_tb.sv ====
`timescale 1ns/1ps

`include "image_mean_config.svh"

module image_mean_tb
   import stream_pkg::*;
   import regs_pkg::*;
();

   localparam int rows = 6;
   localparam int cols = 8;
   localparam int timeout_cycles = 200;

   logic                    pixclk;
   logic                    resetb;
   logic                    reset_req;
   logic                    dvi;
   dtype_e                  dtypei;
   logic [`PIXEL_WIDTH-1:0] datai;
   logic [15:0]             term_addr;
   reg_addr_e               reg_addr;
   logic                    read;
   logic                    write;
   logic [`DATA_WIDTH-1:0]  reg_datai;
   logic [`DATA_WIDTH-1:0]  reg_datao;
   logic                    en;
   logic                    done;
   logic                    busy;
   mean_result_t            result;
   logic                    closing;
   int                      seed;
   int                      errors;
   int                      tests_run;
   int                      tests_passed;
   int                      start_errors;
   logic [7:0]              frame_pix [rows][cols];
   logic [31:0]             exp_val [5];
   logic [31:0]             prev_val [5];
   logic [31:0]             rd_data;
   string                   field_name [5] = '{"result.accum00", "result.accum01",
                                               "result.accum10", "result.accum11",
                                               "result.count"};
   reg_addr_e               win_addr [4] = '{addr_row_start, addr_row_end,
                                             addr_col_start, addr_col_end};
   logic [31:0]             wr_data [4] = '{32'ha5a5_0123, 32'h0000_0456,
                                            32'hffff_f789, 32'h1234_5abc};

   clk_gen u_clk_gen (
      .reset_req (reset_req),
      .pixclk    (pixclk),
      .resetb    (resetb)
   );

   image_mean u_dut (
      .pixclk    (pixclk),
      .resetb    (resetb),
      .dvi       (dvi),
      .dtypei    (dtypei),
      .datai     (datai),
      .term_addr (term_addr),
      .reg_addr  (reg_addr),
      .read      (read),
      .write     (write),
      .reg_datai (reg_datai),
      .reg_datao (reg_datao),
      .en        (en),
      .done      (done),
      .busy      (busy),
      .result    (result)
   );

   task automatic note_failure(input string msg);
      $display("%s", msg);
      errors++;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else begin
         $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
         errors++;
      end
   endtask

   assert property (@(posedge pixclk) en == (term_addr == `TERM_IMAGE_MEAN))
      else note_failure("terminal enable does not match the terminal address");
   assert property (@(posedge pixclk) !en |-> reg_datao == '0)
      else note_failure("register data is not zero while the terminal is deselected");
   assert property (@(posedge pixclk) disable iff (!resetb) done |=> !done)
      else note_failure("done stayed high for more than one cycle");
   assert property (@(posedge pixclk) disable iff (!resetb) done |=> !busy)
      else note_failure("busy did not fall on the edge after done");
   assert property (@(posedge pixclk) disable iff (!resetb)
                    dvi && dtypei == frame_start && !busy |=> !busy ##1 busy)
      else note_failure("busy did not rise two cycles after frame start");
   assert property (@(posedge pixclk) disable iff (!resetb) dvi && closing |=> !done ##1 done)
      else note_failure("done did not follow the closing row end by two cycles");
   assert property (@(posedge pixclk) disable iff (!resetb)
                    $rose(done) |-> $past(dvi && closing, 2))
      else note_failure("done rose without a closing row end");
   assert property (@(posedge pixclk) disable iff (!resetb) !$stable(result) |-> $rose(done))
      else note_failure("result changed without a done pulse");

   function automatic logic [31:0] result_field(input int idx);
      case (idx)
         0: return 32'(result.accum00);
         1: return 32'(result.accum01);
         2: return 32'(result.accum10);
         3: return 32'(result.accum11);
         default: return 32'(result.count);
      endcase
   endfunction

   task automatic step_cycles(input int n);
      repeat (n) begin
         @(posedge pixclk);
         #1;
      end
   endtask

   task automatic send_word(input dtype_e t, input logic [`PIXEL_WIDTH-1:0] d,
                            input logic last);
      dvi = 1'b1;
      dtypei = t;
      datai = d;
      closing = last;
      step_cycles(1);
      dvi = 1'b0;
      closing = 1'b0;
   endtask

   // Rows run up to the one that closes the window.
   task automatic send_frame(input int close_row);
      int r;
      int c;
      send_word(frame_start, '0, 1'b0);
      for (r = 0; r < close_row; r++) begin
         for (c = 0; c < cols; c++) begin
            send_word(c[0] ? pixel_odd : pixel_even, frame_pix[r][c], 1'b0);
         end
         send_word(row_end, '0, r + 1 == close_row);
      end
   endtask

   task automatic write_reg(input logic [15:0] term, input reg_addr_e addr,
                            input logic [31:0] data);
      term_addr = term;
      reg_addr = addr;
      reg_datai = data;
      write = 1'b1;
      step_cycles(1);
      write = 1'b0;
      term_addr = 16'h0;
   endtask

   task automatic read_reg(input reg_addr_e addr, output logic [31:0] data);
      term_addr = `TERM_IMAGE_MEAN;
      reg_addr = addr;
      read = 1'b1;
      #1;
      data = reg_datao;
      step_cycles(1);
      read = 1'b0;
      term_addr = 16'h0;
   endtask

   task automatic set_window(input int rs, input int re, input int cs, input int ce);
      write_reg(`TERM_IMAGE_MEAN, addr_row_start, 32'(rs));
      write_reg(`TERM_IMAGE_MEAN, addr_row_end, 32'(re));
      write_reg(`TERM_IMAGE_MEAN, addr_col_start, 32'(cs));
      write_reg(`TERM_IMAGE_MEAN, addr_col_end, 32'(ce));
   endtask

   task automatic fill_frame();
      int r;
      int c;
      logic [31:0] rnd;
      for (r = 0; r < rows; r++) begin
         for (c = 0; c < cols; c++) begin
            rnd = $random(seed);
            frame_pix[r][c] = rnd[7:0];
         end
      end
   endtask

   // Reference sums, with phase taken as row parity then column parity.
   task automatic model_window(input int rs, input int re, input int cs, input int ce);
      int r;
      int c;
      int ph;
      for (ph = 0; ph < 5; ph++) begin
         exp_val[ph] = 32'h0;
      end
      for (r = rs; r < re; r++) begin
         for (c = cs; c < ce; c++) begin
            ph = (r % 2) * 2 + (c % 2);
            exp_val[ph] = exp_val[ph] + 32'(frame_pix[r][c]);
            if (ph == 0) begin
               exp_val[4] = exp_val[4] + 32'h1;
            end
         end
      end
   endtask

   task automatic check_results(input logic [31:0] vals [5]);
      int i;
      for (i = 0; i < 5; i++) begin
         check_value(field_name[i], result_field(i), vals[i]);
      end
   endtask

   task automatic wait_done();
      int cycles;
      cycles = 0;
      while (done !== 1'b1 && cycles < timeout_cycles) begin
         step_cycles(1);
         cycles++;
      end
      if (done !== 1'b1) begin
         $display("timeout: done did not rise within %0d cycles", timeout_cycles);
         $display("tests failed");
         $finish;
      end
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (resetb !== 1'b1 && cycles < timeout_cycles) begin
         step_cycles(1);
         cycles++;
      end
      if (resetb !== 1'b1) begin
         $display("timeout: reset was never released");
         $display("tests failed");
         $finish;
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors == start_errors) begin
         tests_passed++;
         $display("test %s: pass", name);
      end else begin
         $display("test %s: FAIL with %0d errors", name, errors - start_errors);
      end
   endtask

   task automatic run_frame(input int rs, input int re, input int cs, input int ce);
      set_window(rs, re, cs, ce);
      fill_frame();
      model_window(rs, re, cs, ce);
      send_frame(re);
   endtask

   initial begin
      int i;
      seed = 32'h13b7;
      errors = 0;
      tests_run = 0;
      tests_passed = 0;
      reset_req = 1'b0;
      dvi = 1'b0;
      dtypei = frame_start;
      datai = '0;
      term_addr = 16'h0;
      reg_addr = addr_row_start;
      read = 1'b0;
      write = 1'b0;
      reg_datai = '0;
      closing = 1'b0;
      wait_reset_release();

      start_errors = errors;
      for (i = 0; i < 4; i++) begin
         write_reg(`TERM_IMAGE_MEAN, win_addr[i], wr_data[i]);
      end
      // A write aimed at another terminal must leave the window alone.
      write_reg(`TERM_IMAGE_MEAN ^ 16'h0100, addr_row_start, 32'h0000_0fff);
      for (i = 0; i < 4; i++) begin
         read_reg(win_addr[i], rd_data);
         check_value("reg_datao", rd_data, wr_data[i] & 32'h0000_0fff);
      end
      term_addr = `TERM_IMAGE_MEAN ^ 16'h0100;
      reg_addr = addr_row_end;
      read = 1'b1;
      #1;
      check_value("en", 32'(en), 32'h0);
      check_value("reg_datao", reg_datao, 32'h0);
      step_cycles(1);
      read = 1'b0;
      term_addr = 16'h0;
      finish_test("register access");

      start_errors = errors;
      run_frame(0, rows, 0, cols);
      wait_done();
      check_results(exp_val);
      step_cycles(2);
      finish_test("full frame window");

      start_errors = errors;
      run_frame(1, 4, 2, 6);
      wait_done();
      check_results(exp_val);
      step_cycles(2);
      finish_test("sub window");

      start_errors = errors;
      run_frame(0, 3, 0, cols);
      wait_done();
      check_value("busy", 32'(busy), 32'h1);
      // Status bit 0 reads busy while the done pulse is high.
      read_reg(addr_status, rd_data);
      check_value("reg_datao", rd_data, 32'h1);
      check_value("done", 32'(done), 32'h0);
      check_value("busy", 32'(busy), 32'h0);
      step_cycles(2);
      finish_test("control timing");

      start_errors = errors;
      run_frame(0, rows, 0, cols);
      wait_done();
      check_results(exp_val);
      prev_val = exp_val;
      step_cycles(2);
      run_frame(0, rows, 0, cols);
      check_results(prev_val);
      wait_done();
      check_results(exp_val);
      step_cycles(2);
      finish_test("frame restart");

      start_errors = errors;
      for (i = 0; i < 5; i++) begin
         read_reg(reg_addr_e'(addr_accum00 + i), rd_data);
         check_value("reg_datao", rd_data, result_field(i));
         check_value("reg_datao", rd_data, exp_val[i]);
      end
      // Status bit 0 reads busy. The block is idle here.
      read_reg(addr_status, rd_data);
      check_value("reg_datao", rd_data, 32'h0);
      reset_req = 1'b1;
      step_cycles(1);
      reset_req = 1'b0;
      wait_reset_release();
      check_value("done", 32'(done), 32'h0);
      check_value("busy", 32'(busy), 32'h0);
      check_value("en", 32'(en), 32'h0);
      check_value("reg_datao", reg_datao, 32'h0);
      for (i = 0; i < 5; i++) begin
         check_value(field_name[i], result_field(i), 32'h0);
      end
      for (i = 0; i < 4; i++) begin
         read_reg(win_addr[i], rd_data);
         check_value("reg_datao", rd_data, 32'h0);
      end
      finish_test("readback and reset");

      $display("summary: %0d tests run, %0d passed, %0d check failures",
               tests_run, tests_passed, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// ==== image_mean.f ====
+incdir+include
design/stream_pkg.sv
design/regs_pkg.sv
design/mean_reg_terminal.sv
design/stream_decode.sv
design/bayer_accumulate.sv
design/mean_result.sv
design/image_mean.sv
verif/clk_gen.sv
verif/image_mean_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := image_mean_tb
FILELIST  := image_mean.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "Available targets:"
	@echo "  test  - build with Verilator, run the testbench and check the log"
	@echo "  clean - remove the build directory and the log"
	@echo "  help  - show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "RESULT: PASS"; \
	else \
		echo "RESULT: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
